//--- project.f
+incdir+include
hw/core_pkg.sv
hw/lsq_pkg.sv
hw/lq_alloc.sv
hw/lq_rr_arbiter.sv
hw/lq_entries.sv
hw/lq_forward_check.sv
hw/lq_cache_issue.sv
hw/lq_cdb_broadcast.sv
hw/lq_top.sv
testbench/lq_tb.sv

//--- testbench/lq_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsq_settings.svh"

module lq_tb
    import core_pkg::*, lsq_pkg::*;
();

    localparam int WAIT_LIMIT = 50;

    logic                  clock;
    logic                  arst_n;
    logic                  except;
    logic [`LSQ_WAYS-1:0]  ld_en;
    mem_size_t             ld_size [`LSQ_WAYS];
    rob_idx_t              ld_rob_idx [`LSQ_WAYS];
    prf_idx_t              ld_prf_idx [`LSQ_WAYS];
    sq_ptr_t               ld_sq_tail [`LSQ_WAYS];
    lq_count_t             lq_num_free;
    logic [`LSQ_WAYS-1:0]  alu_valid;
    logic [`LSQ_WAYS-1:0]  alu_is_ls;
    rob_idx_t              alu_rob_idx [`LSQ_WAYS];
    mem_addr_t             alu_addr [`LSQ_WAYS];
    mem_addr_t             store_addr [`LSQ_DEPTH];
    mem_size_t             store_size [`LSQ_DEPTH];
    word_t                 store_data [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0] store_addr_valid;
    logic [`LSQ_DEPTH-1:0] store_data_valid;
    sq_ptr_t               sq_head;
    logic                  rd_en;
    mem_addr_t             rd_addr;
    mem_size_t             rd_size;
    logic                  dc_hit;
    word_t                 dc_data;
    logic                  mem_fill;
    lq_idx_t               mem_fill_idx;
    word_t                 mem_data;
    logic                  cdb_valid;
    word_t                 cdb_data;
    prf_idx_t              cdb_prf_idx;
    rob_idx_t              cdb_rob_idx;

    int checks;
    int mismatches;
    int timeouts;
    int other_errors;
    int unsigned seed_draw;

    lq_top lq_top_i (
        .clock, .arst_n, .except,
        .ld_en, .ld_size, .ld_rob_idx, .ld_prf_idx, .ld_sq_tail, .lq_num_free,
        .alu_valid, .alu_is_ls, .alu_rob_idx, .alu_addr,
        .store_addr, .store_size, .store_data,
        .store_addr_valid, .store_data_valid, .sq_head,
        .rd_en, .rd_addr, .rd_size, .dc_hit, .dc_data,
        .mem_fill, .mem_fill_idx, .mem_data,
        .cdb_valid, .cdb_data, .cdb_prf_idx, .cdb_rob_idx
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // expected CDB value with byte and halfword loads sign extended
    function automatic word_t extend_load(mem_size_t size, word_t raw);
        word_t ext;
        ext = raw;
        if (size == SIZE_BYTE) begin
            ext = raw[7] ? (raw | 32'hffff_ff00) : (raw & 32'h0000_00ff);
        end else if (size == SIZE_HALF) begin
            ext = raw[15] ? (raw | 32'hffff_0000) : (raw & 32'h0000_ffff);
        end
        return ext;
    endfunction

    task check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task check_prf(input string name, input prf_idx_t exp, input prf_idx_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task check_rob(input string name, input rob_idx_t exp, input rob_idx_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task check_size(input string name, input mem_size_t exp, input mem_size_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task check_count(input string name, input lq_count_t exp, input lq_count_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // one load on way 0, allocated at the second edge
    task issue_load(input mem_size_t size, input rob_idx_t rob, input prf_idx_t prf,
                    input sq_ptr_t tail);
        @(posedge clock);
        ld_en[0]      <= 1'b1;
        ld_size[0]    <= size;
        ld_rob_idx[0] <= rob;
        ld_prf_idx[0] <= prf;
        ld_sq_tail[0] <= tail;
        @(posedge clock);
        ld_en <= '0;
    endtask

    // returns on the edge that moves the entry to ready
    task send_addr(input rob_idx_t rob, input mem_addr_t addr);
        @(posedge clock);
        alu_valid[0]   <= 1'b1;
        alu_is_ls[0]   <= 1'b1;
        alu_rob_idx[0] <= rob;
        alu_addr[0]    <= addr;
        @(posedge clock);
        alu_valid <= '0;
        alu_is_ls <= '0;
    endtask

    task place_store(input sq_ptr_t slot, input mem_addr_t addr, input mem_size_t size,
                     input word_t data, input bit data_ready);
        store_addr[slot]       <= addr;
        store_size[slot]       <= size;
        store_data[slot]       <= data;
        store_addr_valid[slot] <= 1'b1;
        store_data_valid[slot] <= data_ready;
    endtask

    task clear_stores;
        @(posedge clock);
        store_addr_valid <= '0;
        store_data_valid <= '0;
        sq_head          <= '0;
    endtask

    task wait_rd_en(input string name, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clock);
            seen = rd_en;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("%s: timed out waiting for a cache read request", name);
        end
    endtask

    task wait_cdb(input string name, input bit forbid_rd, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clock);
            if (forbid_rd && rd_en) begin
                other_errors++;
                $display("%s: cache read issued for a load that should forward", name);
            end
            seen = cdb_valid;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("%s: timed out waiting for a CDB broadcast", name);
        end
    endtask

    // cache answers in the same cycle as the request
    task answer_hit(input string name, input mem_addr_t addr, input mem_size_t size,
                    input word_t data);
        bit seen;
        dc_hit  <= 1'b1;
        dc_data <= data;
        wait_rd_en(name, seen);
        if (seen) begin
            check_addr(name, addr, rd_addr);
            check_size(name, size, rd_size);
        end
        @(posedge clock);
        dc_hit <= 1'b0;
    endtask

    task expect_result(input string name, input word_t data, input prf_idx_t prf,
                       input rob_idx_t rob, input bit forbid_rd);
        bit seen;
        wait_cdb(name, forbid_rd, seen);
        if (seen) begin
            check_word(name, data, cdb_data);
            check_prf(name, prf, cdb_prf_idx);
            check_rob(name, rob, cdb_rob_idx);
        end
        @(posedge clock);
    endtask

    task test_after_reset;
        @(negedge clock);
        check_count("after_reset", lq_count_t'(8), lq_num_free);
        check_bit("after_reset rd_en", 1'b0, rd_en);
        check_bit("after_reset cdb_valid", 1'b0, cdb_valid);
    endtask

    task test_cache_hit;
        word_t data;
        data = $urandom();
        data[7] = 1'b1;
        issue_load(SIZE_BYTE, 5'd3, 6'd17, 3'd0);
        send_addr(5'd3, 16'h1235);
        answer_hit("cache_hit", 16'h1235, SIZE_BYTE, data);
        expect_result("cache_hit", extend_load(SIZE_BYTE, data), 6'd17, 5'd3, 1'b0);
    endtask

    task test_miss_fill;
        word_t mdata;
        bit    seen;
        mdata = $urandom();
        issue_load(SIZE_WORD, 5'd7, 6'd33, 3'd0);
        send_addr(5'd7, 16'h0a40);
        wait_rd_en("miss_fill", seen);
        if (seen) begin
            check_addr("miss_fill", 16'h0a40, rd_addr);
        end
        // without dc_hit this edge parks entry 0 in the miss state
        @(posedge clock);
        mem_fill     <= 1'b1;
        mem_fill_idx <= 3'd0;
        mem_data     <= mdata;
        @(negedge clock);
        check_bit("miss_fill cdb before fill", 1'b0, cdb_valid);
        @(posedge clock);
        mem_fill <= 1'b0;
        expect_result("miss_fill", mdata, 6'd33, 5'd7, 1'b0);
    endtask

    task test_forward;
        word_t sdata;
        sdata = $urandom();
        sdata[15] = 1'b1;
        @(posedge clock);
        // slot 1 is inside head 0 .. snapshot 2
        place_store(3'd1, 16'h2206, SIZE_HALF, sdata, 1'b1);
        sq_head <= 3'd0;
        issue_load(SIZE_HALF, 5'd9, 6'd41, 3'd2);
        send_addr(5'd9, 16'h2206);
        expect_result("forward", extend_load(SIZE_HALF, sdata), 6'd41, 5'd9, 1'b1);
        clear_stores();
    endtask

    task test_younger_store;
        word_t sdata;
        word_t cdata;
        sdata = $urandom();
        cdata = $urandom();
        @(posedge clock);
        // both slots fall outside head 0 .. snapshot 2
        place_store(3'd2, 16'h3310, SIZE_WORD, sdata, 1'b1);
        place_store(3'd5, 16'h3310, SIZE_WORD, sdata, 1'b1);
        sq_head <= 3'd0;
        issue_load(SIZE_WORD, 5'd12, 6'd5, 3'd2);
        send_addr(5'd12, 16'h3310);
        answer_hit("younger_store", 16'h3310, SIZE_WORD, cdata);
        expect_result("younger_store", cdata, 6'd5, 5'd12, 1'b0);
        clear_stores();
    endtask

    task test_dual_flush;
        int n;
        @(posedge clock);
        // older store in slot 0 with its data pending holds both loads in ready
        place_store(3'd0, 16'h4400, SIZE_WORD, $urandom(), 1'b0);
        sq_head       <= 3'd0;
        ld_en         <= 2'b11;
        ld_size[0]    <= SIZE_WORD;
        ld_size[1]    <= SIZE_WORD;
        ld_rob_idx[0] <= 5'd20;
        ld_rob_idx[1] <= 5'd21;
        ld_prf_idx[0] <= 6'd50;
        ld_prf_idx[1] <= 6'd51;
        ld_sq_tail[0] <= 3'd1;
        ld_sq_tail[1] <= 3'd1;
        @(posedge clock);
        ld_en <= '0;
        @(posedge clock);
        @(negedge clock);
        check_count("dual_flush", lq_count_t'(6), lq_num_free);
        send_addr(5'd20, 16'h4400);
        send_addr(5'd21, 16'h4400);
        @(posedge clock);
        except <= 1'b1;
        @(posedge clock);
        except <= 1'b0;
        // store data arrives, a surviving load would forward now
        store_data_valid[0] <= 1'b1;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (cdb_valid) begin
                other_errors++;
                $display("dual_flush: CDB broadcast from a flushed entry");
            end
        end while (lq_num_free !== lq_count_t'(8) && n < WAIT_LIMIT);
        if (lq_num_free !== lq_count_t'(8)) begin
            timeouts++;
            $display("dual_flush: timed out waiting for the queue to drain");
        end
        check_count("dual_flush after except", lq_count_t'(8), lq_num_free);
        repeat (8) begin
            @(negedge clock);
            if (cdb_valid) begin
                other_errors++;
                $display("dual_flush: CDB broadcast from a flushed entry");
            end
        end
        clear_stores();
    endtask

    initial begin
        seed_draw = $urandom(69367);
        checks = 0;
        mismatches = 0;
        timeouts = 0;
        other_errors = 0;
        arst_n = 1'b0;
        except = 1'b0;
        ld_en = '0;
        alu_valid = '0;
        alu_is_ls = '0;
        for (int w = 0; w < `LSQ_WAYS; w++) begin
            ld_size[w] = SIZE_WORD;
            ld_rob_idx[w] = '0;
            ld_prf_idx[w] = '0;
            ld_sq_tail[w] = '0;
            alu_rob_idx[w] = '0;
            alu_addr[w] = '0;
        end
        for (int s = 0; s < `LSQ_DEPTH; s++) begin
            store_addr[s] = '0;
            store_size[s] = SIZE_WORD;
            store_data[s] = '0;
        end
        store_addr_valid = '0;
        store_data_valid = '0;
        sq_head = '0;
        dc_hit = 1'b0;
        dc_data = '0;
        mem_fill = 1'b0;
        mem_fill_idx = '0;
        mem_data = '0;

        repeat (16) @(posedge clock);
        arst_n <= 1'b1;

        test_after_reset();
        test_cache_hit();
        test_miss_fill();
        test_forward();
        test_younger_store();
        test_dual_flush();

        $display("summary: %0d checks, %0d mismatches, %0d timeouts, %0d other errors",
                 checks, mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/lq_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsq_settings.svh"

module lq_top
    import core_pkg::*, lsq_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  except,
    // load issue
    input  logic [`LSQ_WAYS-1:0]  ld_en,
    input  mem_size_t             ld_size [`LSQ_WAYS],
    input  rob_idx_t              ld_rob_idx [`LSQ_WAYS],
    input  prf_idx_t              ld_prf_idx [`LSQ_WAYS],
    input  sq_ptr_t               ld_sq_tail [`LSQ_WAYS],
    output lq_count_t             lq_num_free,
    // ALU
    input  logic [`LSQ_WAYS-1:0]  alu_valid,
    input  logic [`LSQ_WAYS-1:0]  alu_is_ls,
    input  rob_idx_t              alu_rob_idx [`LSQ_WAYS],
    input  mem_addr_t             alu_addr [`LSQ_WAYS],
    // store queue
    input  mem_addr_t             store_addr [`LSQ_DEPTH],
    input  mem_size_t             store_size [`LSQ_DEPTH],
    input  word_t                 store_data [`LSQ_DEPTH],
    input  logic [`LSQ_DEPTH-1:0] store_addr_valid,
    input  logic [`LSQ_DEPTH-1:0] store_data_valid,
    input  sq_ptr_t               sq_head,
    // data cache
    output logic                  rd_en,
    output mem_addr_t             rd_addr,
    output mem_size_t             rd_size,
    input  logic                  dc_hit,
    input  word_t                 dc_data,
    // memory
    input  logic                  mem_fill,
    input  lq_idx_t               mem_fill_idx,
    input  word_t                 mem_data,
    // CDB
    output logic                  cdb_valid,
    output word_t                 cdb_data,
    output prf_idx_t              cdb_prf_idx,
    output rob_idx_t              cdb_rob_idx
);

    lq_mask_t              entry_free;
    lq_mask_t              alloc_we;
    logic [`LSQ_DEPTH-1:0] alloc_way;
    lq_state_t             entry_state [`LSQ_DEPTH];
    mem_addr_t             entry_addr [`LSQ_DEPTH];
    mem_size_t             entry_size [`LSQ_DEPTH];
    sq_ptr_t               entry_sq_tail [`LSQ_DEPTH];
    word_t                 entry_data [`LSQ_DEPTH];
    rob_idx_t              entry_rob_idx [`LSQ_DEPTH];
    prf_idx_t              entry_prf_idx [`LSQ_DEPTH];
    lq_mask_t              fwd_done;
    word_t                 fwd_data [`LSQ_DEPTH];
    lq_mask_t              cache_ok;
    lq_mask_t              rd_gnt;
    lq_mask_t              cdb_gnt;

    lq_alloc lq_alloc_i (
        .entry_free, .ld_en, .alloc_we, .alloc_way
    );

    lq_entries lq_entries_i (
        .clock, .arst_n, .except,
        .alloc_we, .alloc_way,
        .ld_en, .ld_size, .ld_rob_idx, .ld_prf_idx, .ld_sq_tail,
        .alu_valid, .alu_is_ls, .alu_rob_idx, .alu_addr,
        .fwd_done, .fwd_data, .rd_gnt,
        .dc_hit, .dc_data, .mem_fill, .mem_fill_idx, .mem_data,
        .cdb_gnt,
        .entry_state, .entry_addr, .entry_size, .entry_sq_tail,
        .entry_data, .entry_rob_idx, .entry_prf_idx,
        .entry_free, .lq_num_free
    );

    lq_forward_check lq_forward_check_i (
        .entry_state, .entry_addr, .entry_size, .entry_sq_tail,
        .store_addr, .store_size, .store_data,
        .store_addr_valid, .store_data_valid, .sq_head,
        .fwd_done, .fwd_data, .cache_ok
    );

    lq_cache_issue lq_cache_issue_i (
        .clock, .arst_n, .cache_ok, .entry_addr, .entry_size,
        .rd_gnt, .rd_en, .rd_addr, .rd_size
    );

    lq_cdb_broadcast lq_cdb_broadcast_i (
        .clock, .arst_n,
        .entry_state, .entry_data, .entry_size, .entry_rob_idx, .entry_prf_idx,
        .cdb_gnt, .cdb_valid, .cdb_data, .cdb_rob_idx, .cdb_prf_idx
    );

endmodule

`default_nettype wire

//--- hw/lq_cdb_broadcast.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsq_settings.svh"

module lq_cdb_broadcast
    import core_pkg::*, lsq_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  lq_state_t entry_state [`LSQ_DEPTH],
    input  word_t     entry_data [`LSQ_DEPTH],
    input  mem_size_t entry_size [`LSQ_DEPTH],
    input  rob_idx_t  entry_rob_idx [`LSQ_DEPTH],
    input  prf_idx_t  entry_prf_idx [`LSQ_DEPTH],
    output lq_mask_t  cdb_gnt,
    output logic      cdb_valid,
    output word_t     cdb_data,
    output rob_idx_t  cdb_rob_idx,
    output prf_idx_t  cdb_prf_idx
);

    lq_mask_t  done_req;
    word_t     raw_data;
    mem_size_t sel_size;

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            done_req[i] = entry_state[i] == ENTRY_DONE;
        end
    end

    lq_rr_arbiter #(.WIDTH(`LSQ_DEPTH)) cdb_arb_i (
        .clock (clock),
        .arst_n(arst_n),
        .req   (done_req),
        .gnt   (cdb_gnt)
    );

    // CDB never stalls, a grant always retires
    assign cdb_valid = |cdb_gnt;

    always_comb begin
        raw_data    = '0;
        sel_size    = SIZE_WORD;
        cdb_rob_idx = '0;
        cdb_prf_idx = '0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (cdb_gnt[i]) begin
                raw_data    = entry_data[i];
                sel_size    = entry_size[i];
                cdb_rob_idx = entry_rob_idx[i];
                cdb_prf_idx = entry_prf_idx[i];
            end
        end
    end

    // sign extend narrow loads
    always_comb begin
        case (sel_size)
            SIZE_BYTE: cdb_data = {{24{raw_data[7]}}, raw_data[7:0]};
            SIZE_HALF: cdb_data = {{16{raw_data[15]}}, raw_data[15:0]};
            default:   cdb_data = raw_data;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/lq_cache_issue.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsq_settings.svh"

module lq_cache_issue
    import core_pkg::*, lsq_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  lq_mask_t  cache_ok,
    input  mem_addr_t entry_addr [`LSQ_DEPTH],
    input  mem_size_t entry_size [`LSQ_DEPTH],
    output lq_mask_t  rd_gnt,
    output logic      rd_en,
    output mem_addr_t rd_addr,
    output mem_size_t rd_size
);

    lq_rr_arbiter #(.WIDTH(`LSQ_DEPTH)) rd_arb_i (
        .clock (clock),
        .arst_n(arst_n),
        .req   (cache_ok),
        .gnt   (rd_gnt)
    );

    assign rd_en = |rd_gnt;

    // one read port, mux in the granted load
    always_comb begin
        rd_addr = '0;
        rd_size = SIZE_BYTE;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (rd_gnt[i]) begin
                rd_addr = entry_addr[i];
                rd_size = entry_size[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lq_forward_check.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsq_settings.svh"

module lq_forward_check
    import core_pkg::*, lsq_pkg::*;
(
    input  lq_state_t             entry_state [`LSQ_DEPTH],
    input  mem_addr_t             entry_addr [`LSQ_DEPTH],
    input  mem_size_t             entry_size [`LSQ_DEPTH],
    input  sq_ptr_t               entry_sq_tail [`LSQ_DEPTH],
    input  mem_addr_t             store_addr [`LSQ_DEPTH],
    input  mem_size_t             store_size [`LSQ_DEPTH],
    input  word_t                 store_data [`LSQ_DEPTH],
    input  logic [`LSQ_DEPTH-1:0] store_addr_valid,
    input  logic [`LSQ_DEPTH-1:0] store_data_valid,
    input  sq_ptr_t               sq_head,
    output lq_mask_t              fwd_done,
    output word_t                 fwd_data [`LSQ_DEPTH],
    output lq_mask_t              cache_ok
);

    // slot lies in [head, tail) of the circular store queue
    function automatic logic is_older(sq_ptr_t slot, sq_ptr_t head, sq_ptr_t tail);
        if (head <= tail) begin
            return (slot >= head) && (slot < tail);
        end
        return (slot >= head) || (slot < tail);
    endfunction

    always_comb begin
        sq_ptr_t slot;
        sq_ptr_t sel;
        logic    found;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            sel   = '0;
            found = 1'b0;
            // walk toward the snapshot, so the youngest older store is kept
            for (int k = `LSQ_DEPTH; k >= 1; k--) begin
                slot = entry_sq_tail[i] - sq_ptr_t'(k);
                if (is_older(slot, sq_head, entry_sq_tail[i]) && store_addr_valid[slot]
                        && store_addr[slot][`LSQ_ADDR_W-1:3] == entry_addr[i][`LSQ_ADDR_W-1:3])
                begin
                    sel   = slot;
                    found = 1'b1;
                end
            end

            fwd_data[i] = store_data[sel];
            // same block but not an exact match means wait for the store
            fwd_done[i] = entry_state[i] == ENTRY_READY && found
                && store_addr[sel] == entry_addr[i]
                && store_size[sel] == entry_size[i]
                && store_data_valid[sel];
            cache_ok[i] = entry_state[i] == ENTRY_READY && !found;
        end
    end

endmodule

`default_nettype wire

//--- hw/lq_entries.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsq_settings.svh"

module lq_entries
    import core_pkg::*, lsq_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  except,
    input  lq_mask_t              alloc_we,
    input  logic [`LSQ_DEPTH-1:0] alloc_way,
    // load issue
    input  logic [`LSQ_WAYS-1:0]  ld_en,
    input  mem_size_t             ld_size [`LSQ_WAYS],
    input  rob_idx_t              ld_rob_idx [`LSQ_WAYS],
    input  prf_idx_t              ld_prf_idx [`LSQ_WAYS],
    input  sq_ptr_t               ld_sq_tail [`LSQ_WAYS],
    // ALU address broadcast
    input  logic [`LSQ_WAYS-1:0]  alu_valid,
    input  logic [`LSQ_WAYS-1:0]  alu_is_ls,
    input  rob_idx_t              alu_rob_idx [`LSQ_WAYS],
    input  mem_addr_t             alu_addr [`LSQ_WAYS],
    // completion sources
    input  lq_mask_t              fwd_done,
    input  word_t                 fwd_data [`LSQ_DEPTH],
    input  lq_mask_t              rd_gnt,
    input  logic                  dc_hit,
    input  word_t                 dc_data,
    input  logic                  mem_fill,
    input  lq_idx_t               mem_fill_idx,
    input  word_t                 mem_data,
    input  lq_mask_t              cdb_gnt,
    output lq_state_t             entry_state [`LSQ_DEPTH],
    output mem_addr_t             entry_addr [`LSQ_DEPTH],
    output mem_size_t             entry_size [`LSQ_DEPTH],
    output sq_ptr_t               entry_sq_tail [`LSQ_DEPTH],
    output word_t                 entry_data [`LSQ_DEPTH],
    output rob_idx_t              entry_rob_idx [`LSQ_DEPTH],
    output prf_idx_t              entry_prf_idx [`LSQ_DEPTH],
    output lq_mask_t              entry_free,
    output lq_count_t             lq_num_free
);

    lq_state_t state_next [`LSQ_DEPTH];
    lq_mask_t  addr_hit;
    mem_addr_t addr_val [`LSQ_DEPTH];
    lq_mask_t  data_we;
    word_t     data_val [`LSQ_DEPTH];
    lq_count_t free_cnt;

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            // ALU broadcast on any way, matched by ROB index
            addr_hit[i] = 1'b0;
            addr_val[i] = alu_addr[0];
            for (int w = 0; w < `LSQ_WAYS; w++) begin
                if (alu_valid[w] && alu_is_ls[w] && entry_state[i] == ENTRY_WAIT_ADDR
                        && alu_rob_idx[w] == entry_rob_idx[i]) begin
                    addr_hit[i] = 1'b1;
                    addr_val[i] = alu_addr[w];
                end
            end

            state_next[i] = entry_state[i];
            data_we[i]    = 1'b0;
            data_val[i]   = fwd_data[i];
            case (entry_state[i])
                ENTRY_FREE: begin
                    if (alloc_we[i]) begin
                        state_next[i] = ENTRY_WAIT_ADDR;
                    end
                end
                ENTRY_WAIT_ADDR: begin
                    if (addr_hit[i]) begin
                        state_next[i] = ENTRY_READY;
                    end
                end
                ENTRY_READY: begin
                    if (fwd_done[i]) begin
                        state_next[i] = ENTRY_DONE;
                        data_we[i]    = 1'b1;
                    end else if (rd_gnt[i]) begin
                        state_next[i] = dc_hit ? ENTRY_DONE : ENTRY_MISS;
                        data_we[i]    = dc_hit;
                        data_val[i]   = dc_data;
                    end
                end
                ENTRY_MISS: begin
                    if (mem_fill && mem_fill_idx == lq_idx_t'(i)) begin
                        state_next[i] = ENTRY_DONE;
                        data_we[i]    = 1'b1;
                        data_val[i]   = mem_data;
                    end
                end
                ENTRY_DONE: begin
                    if (cdb_gnt[i]) begin
                        state_next[i] = ENTRY_FREE;
                    end
                end
                default: state_next[i] = ENTRY_FREE;
            endcase

            // flush drops everything in flight
            if (except) begin
                state_next[i] = ENTRY_FREE;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                entry_state[i] <= ENTRY_FREE;
            end
        end else begin
            for (int i = 0; i < `LSQ_DEPTH; i++) begin
                entry_state[i] <= state_next[i];
            end
        end
    end

    // payload follows the state machine
    always_ff @(posedge clock) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (alloc_we[i]) begin
                entry_size[i]    <= ld_size[alloc_way[i]];
                entry_rob_idx[i] <= ld_rob_idx[alloc_way[i]];
                entry_prf_idx[i] <= ld_prf_idx[alloc_way[i]];
                entry_sq_tail[i] <= ld_sq_tail[alloc_way[i]];
            end
            if (addr_hit[i]) begin
                entry_addr[i] <= addr_val[i];
            end
            if (data_we[i]) begin
                entry_data[i] <= data_val[i];
            end
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            entry_free[i] = entry_state[i] == ENTRY_FREE;
            free_cnt      = free_cnt + lq_count_t'(entry_free[i]);
        end
    end

    // below two free entries a dual issue could overflow, so report none
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lq_num_free <= lq_count_t'(`LSQ_DEPTH);
        end else begin
            lq_num_free <= (free_cnt < `LSQ_WAYS) ? '0 : free_cnt;
        end
    end

    a_fill_to_miss: assert property (@(posedge clock) disable iff (!arst_n)
        mem_fill |-> entry_state[mem_fill_idx] == ENTRY_MISS)
        else $error("lq_entries: mem_fill to an entry not waiting on memory");

    a_hit_with_gnt: assert property (@(posedge clock) disable iff (!arst_n)
        dc_hit |-> |rd_gnt)
        else $error("lq_entries: dc_hit without a cache read");

    // every enabled way lands in exactly one entry
    a_alloc_per_way: assert property (@(posedge clock) disable iff (!arst_n)
        $countones(alloc_we) == $countones(ld_en))
        else $error("lq_entries: allocation does not match enabled ways");

endmodule

`default_nettype wire

//--- hw/lq_rr_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module lq_rr_arbiter #(
    parameter int WIDTH = 8
) (
    input  logic             clock,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    localparam int IDX_W = $clog2(WIDTH);

    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] gnt_idx;

    // farthest slot first, the one right after last_q overrides
    always_comb begin
        int pos;
        gnt     = '0;
        gnt_idx = last_q;
        for (int k = WIDTH; k >= 1; k--) begin
            pos = (int'(last_q) + k) % WIDTH;
            if (req[pos]) begin
                gnt      = '0;
                gnt[pos] = 1'b1;
                gnt_idx  = IDX_W'(pos);
            end
        end
    end

    // start so that slot 0 wins first
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            last_q <= IDX_W'(WIDTH - 1);
        end else if (|gnt) begin
            last_q <= gnt_idx;
        end
    end

    a_gnt_legal: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(gnt) && (gnt & ~req) == '0)
        else $error("lq_rr_arbiter: grant not one-hot or outside req");

endmodule

`default_nettype wire

//--- hw/lq_alloc.sv
`default_nettype none
`timescale 1ns/1ps

`include "lsq_settings.svh"

module lq_alloc
    import lsq_pkg::*;
(
    input  lq_mask_t                  entry_free,
    input  logic     [`LSQ_WAYS-1:0]  ld_en,
    output lq_mask_t                  alloc_we,
    output logic     [`LSQ_DEPTH-1:0] alloc_way
);

    lq_mask_t lo_pick;
    lq_mask_t hi_pick;
    lq_mask_t hi_avail;

    // isolate the lowest free entry for way 0
    assign lo_pick = entry_free & (~entry_free + lq_mask_t'(1));

    // way 1 may not share the entry taken by way 0
    assign hi_avail = entry_free & ~(ld_en[0] ? lo_pick : '0);

    // scan up, last hit is the highest free entry
    always_comb begin
        hi_pick = '0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (hi_avail[i]) begin
                hi_pick    = '0;
                hi_pick[i] = 1'b1;
            end
        end
    end

    assign alloc_we = (ld_en[0] ? lo_pick : '0) | (ld_en[1] ? hi_pick : '0);

    // set bit means the entry is filled from way 1
    assign alloc_way = ld_en[1] ? hi_pick : '0;

    // issue side must respect lq_num_free
    always_comb begin
        assert final ((!ld_en[0] || |entry_free) && (!ld_en[1] || |hi_avail))
            else $error("lq_alloc: enabled way found no free entry");
    end

endmodule

`default_nettype wire

//--- hw/lsq_pkg.sv
`default_nettype none

`include "lsq_settings.svh"

package lsq_pkg;

    typedef logic [$clog2(`LSQ_DEPTH)-1:0] lq_idx_t;
    typedef logic [$clog2(`LSQ_DEPTH)-1:0] sq_ptr_t;
    typedef logic [`LSQ_DEPTH-1:0] lq_mask_t;

    // holds 0 up to the full depth
    typedef logic [$clog2(`LSQ_DEPTH):0] lq_count_t;

    // life of one load queue entry
    typedef enum logic [2:0] {
        ENTRY_FREE      = 3'd0,
        ENTRY_WAIT_ADDR = 3'd1,
        ENTRY_READY     = 3'd2,
        ENTRY_MISS      = 3'd3,
        ENTRY_DONE      = 3'd4
    } lq_state_t;

endpackage

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

`include "lsq_settings.svh"

package core_pkg;

    // data word as carried on the CDB
    typedef logic [31:0] word_t;

    // bits 15..3 select the block, bits 2..0 the byte
    typedef logic [`LSQ_ADDR_W-1:0] mem_addr_t;

    typedef logic [$clog2(`LSQ_ROB_SIZE)-1:0] rob_idx_t;
    typedef logic [$clog2(`LSQ_PRF_SIZE)-1:0] prf_idx_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

endpackage

`default_nettype wire

//--- include/lsq_settings.svh
`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// entries in the load queue, and slots in the store queue
`define LSQ_DEPTH 8

// loads accepted per cycle
`define LSQ_WAYS 2

// reorder buffer and physical register file
`define LSQ_ROB_SIZE 32
`define LSQ_PRF_SIZE 64

// byte address, block in the upper bits and offset in 2..0
`define LSQ_ADDR_W 16

`endif
